/* src.f */
design/fcore_pkg.sv
design/issue_if.sv
design/instruction_decoder.sv
design/register_bank.sv
design/alu_writeback.sv
design/fcore_slice.sv
tests/fcore_slice_assert.sv
tests/fcore_slice_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core slice testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module fcore_slice_tb -f src.f -o fcore_slice_sim \
    && ./obj_dir/fcore_slice_sim | tee /dev/stderr | grep "Verification passed" > /dev/null \
    && echo "Simulation run ended with a pass" \
    || { echo "Simulation run ended with a failure"; exit 1; }

/* tests/fcore_vectors.txt */
// instruction channel write_flag write_address write_data stop_flag, all hex
// A write_flag of f marks the end of the list
1216 0 1 01 0012 0
0526 0 1 02 0005 0
ff36 0 1 03 00ff 0
4211 0 1 04 0017 0
5122 0 1 05 fff3 0
6035 0 1 06 ff00 0
7313 0 1 07 0012 0
8661 0 1 08 fe00 0
9644 0 1 09 ff17 0
a528 0 1 0a 0001 0
b258 0 1 0b 0000 0
c177 0 1 0c 0001 0
d217 0 1 0d 0000 0
0000 0 0 00 0000 0
1239 0 0 00 0000 0
ffff 1 0 00 0000 0
4016 1 1 11 0040 0
0326 1 1 12 0003 0
000d 2 0 00 0000 0
4211 1 1 14 0043 0
4211 0 1 04 0017 0
5142 1 1 15 0003 0
000c 0 0 00 0000 1
80f6 3 1 3f 0080 0
0000 3 0 00 0000 0
0ff7 3 1 30 0001 0
000c 2 0 00 0000 1
0000 0 f 00 0000 0

/* tests/fcore_slice_tb.sv */
// Core slice testbench with vector stimulus, writeback and stop checking and a watchdog
`timescale 1ns/100ps
`default_nettype none

module fcore_slice_tb;
    import fcore_pkg::*;

    localparam int CHANNEL_ADDR_WIDTH = 2;
    localparam int ADDR_WIDTH = CHANNEL_ADDR_WIDTH + 4;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_LINES = 64;
    localparam int COLUMNS = 6;
    localparam int INDEX_WIDTH = $clog2(MAX_LINES * COLUMNS);
    localparam logic [15:0] END_MARK = 16'h000f;

    logic                          clock;
    logic                          rst;
    logic                          enable;
    instr_t                        instruction;
    logic [CHANNEL_ADDR_WIDTH-1:0] channel_address;
    logic                          result_valid;
    logic [ADDR_WIDTH-1:0]         result_address;
    data_t                         result_data;
    logic                          core_stop;

    logic [15:0] vector_words [MAX_LINES*COLUMNS];
    int          line_count = 0;
    bit          vectors_loaded = 1'b0;
    int          cycle = 0;
    logic [16:0] lfsr_state;

    // Each pending writeback keeps the cycle count at which it must show up
    int                    expected_cycle [$];
    logic [ADDR_WIDTH-1:0] expected_address [$];
    data_t                 expected_data [$];
    int                    expected_stop [$];

    fcore_slice #(
        .CHANNEL_ADDR_WIDTH(CHANNEL_ADDR_WIDTH)
    ) i_fcore_slice (
        .clock(clock),
        .rst(rst),
        .enable(enable),
        .instruction(instruction),
        .channel_address(channel_address),
        .result_valid(result_valid),
        .result_address(result_address),
        .result_data(result_data),
        .core_stop(core_stop)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Taps at bits 17 and 14 give a maximal length sequence
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    function automatic logic [15:0] word_at(input int line, input int column);
        return vector_words[INDEX_WIDTH'(line * COLUMNS + column)];
    endfunction

    task automatic next_idle_count(output int count);
        logic [1:0] bits;
        lfsr_state = lfsr_step(lfsr_state);
        bits[0] = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        bits[1] = lfsr_state[0];
        count = int'(bits);
    endtask

    task automatic stop_on_failure();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_failure(input string message);
        $display("%0t: %s", $time, message);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic load_vectors();
        $readmemh("tests/fcore_vectors.txt", vector_words);
        while (line_count < MAX_LINES && word_at(line_count, 2) != END_MARK) begin
            line_count++;
        end
        if (line_count == 0 || line_count == MAX_LINES) begin
            report_failure("vector file is missing or has no end marker line");
        end
    endtask

    // Called on a falling edge, so the next rising edge samples the line
    task automatic apply_line(input int line);
        logic [15:0] channel_word;
        logic [15:0] address_word;
        channel_word = word_at(line, 1);
        address_word = word_at(line, 3);
        enable = 1'b1;
        instruction = word_at(line, 0);
        channel_address = channel_word[CHANNEL_ADDR_WIDTH-1:0];
        if (word_at(line, 2) == 16'd1) begin
            expected_cycle.push_back(cycle + 3);
            expected_address.push_back(address_word[ADDR_WIDTH-1:0]);
            expected_data.push_back(word_at(line, 4));
        end
        if (word_at(line, 5) == 16'd1) begin
            expected_stop.push_back(cycle + 1);
        end
    endtask

    task automatic run_vectors();
        int idle;
        for (int line = 0; line < line_count; line++) begin
            apply_line(line);
            @(negedge clock);
            next_idle_count(idle);
            // The instruction stays on the bus, so gating by enable is exercised too
            enable = 1'b0;
            repeat (idle) @(negedge clock);
        end
        enable = 1'b0;
    endtask

    task automatic check_outputs();
        if (result_valid !== 1'b0) begin
            if (expected_cycle.size() == 0) begin
                report_failure("result_valid went high with no writeback pending");
            end else begin
                check_value("result_valid", 32'(result_valid), 32'd1);
                check_value("writeback cycle", cycle, expected_cycle.pop_front());
                check_value("result_address", 32'(result_address),
                            32'(expected_address.pop_front()));
                check_value("result_data", 32'(result_data), 32'(expected_data.pop_front()));
            end
        end else if (expected_cycle.size() != 0 && expected_cycle[0] <= cycle) begin
            report_failure("an expected writeback did not appear");
        end
        if (core_stop !== 1'b0) begin
            if (expected_stop.size() == 0) begin
                report_failure("core_stop went high with no STOP pending");
            end else begin
                check_value("core_stop", 32'(core_stop), 32'd1);
                check_value("core_stop cycle", cycle, expected_stop.pop_front());
            end
        end else if (expected_stop.size() != 0 && expected_stop[0] <= cycle) begin
            report_failure("an expected core_stop pulse did not appear");
        end
    endtask

    // Outputs are registered, so mid-cycle they are settled
    always @(negedge clock) begin
        if (cycle >= RESET_CYCLES) begin
            check_outputs();
        end
    end

    initial begin
        wait (vectors_loaded);
        repeat (line_count * 8 + 20) @(posedge clock);
        report_failure("watchdog timeout before the vectors completed");
    end

    initial begin
        rst = 1'b1;
        enable = 1'b0;
        instruction = '0;
        channel_address = '0;
        lfsr_state = 17'd93852;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        run_vectors();
        // The last writeback lands three cycles after its sampling edge,
        // and the spare cycles catch late or extra outputs
        repeat (4) @(negedge clock);
        if (expected_cycle.size() == 0 && expected_stop.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            report_failure("writebacks or stop pulses still outstanding at the end");
        end
    end

endmodule

`default_nettype wire

/* tests/fcore_slice_assert.sv */
// Concurrent assertions on the core slice outputs and their bind into the top level
`timescale 1ns/100ps
`default_nettype none

module fcore_slice_assert (
    input logic             clock,
    input logic             rst,
    input logic             result_valid,
    input fcore_pkg::data_t result_data,
    input logic             core_stop
);

    // A STOP gives a single pulse, and the vectors never place two STOPs back to back
    property stop_is_one_cycle;
        @(posedge clock) disable iff (rst) core_stop |=> !core_stop;
    endproperty

    property quiet_after_reset;
        @(posedge clock) rst |=> (!result_valid && !core_stop);
    endproperty

    property data_known_on_valid;
        @(posedge clock) disable iff (rst) result_valid |-> !$isunknown(result_data);
    endproperty

    stop_pulse_check: assert property (stop_is_one_cycle)
        else $error("core_stop stayed high for two cycles");

    reset_check: assert property (quiet_after_reset)
        else $error("result_valid or core_stop high in the cycle after reset");

    data_check: assert property (data_known_on_valid)
        else $error("result_data unknown while result_valid is high");

endmodule

bind fcore_slice fcore_slice_assert i_fcore_slice_assert (
    .clock(clock),
    .rst(rst),
    .result_valid(result_valid),
    .result_data(result_data),
    .core_stop(core_stop)
);

`default_nettype wire

/* design/fcore_slice.sv */
// Core slice top level with decoder, duplicated register banks and ALU
`timescale 1ns/100ps
`default_nettype none

module fcore_slice #(
    parameter int CHANNEL_ADDR_WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          enable,
    input  fcore_pkg::instr_t             instruction,
    input  logic [CHANNEL_ADDR_WIDTH-1:0] channel_address,
    output logic                          result_valid,
    output logic [CHANNEL_ADDR_WIDTH+3:0] result_address,
    output fcore_pkg::data_t              result_data,
    output logic                          core_stop
);
    import fcore_pkg::*;

    logic [CHANNEL_ADDR_WIDTH+3:0] operand_a_address;
    logic [CHANNEL_ADDR_WIDTH+3:0] operand_b_address;
    data_t                         a_data;
    data_t                         b_data;

    issue_if #(
        .CHANNEL_ADDR_WIDTH(CHANNEL_ADDR_WIDTH)
    ) issue ();

    instruction_decoder #(
        .CHANNEL_ADDR_WIDTH(CHANNEL_ADDR_WIDTH)
    ) decoder (
        .clock(clock),
        .rst(rst),
        .enable(enable),
        .instruction(instruction),
        .channel_address(channel_address),
        .operand_a_address(operand_a_address),
        .operand_b_address(operand_b_address),
        .core_stop(core_stop),
        .issue(issue.master)
    );

    // Both banks see every write, so they always hold the same contents
    register_bank #(
        .CHANNEL_ADDR_WIDTH(CHANNEL_ADDR_WIDTH)
    ) bank_a (
        .clock(clock),
        .rd_address(operand_a_address),
        .read_data(a_data),
        .wr_valid(result_valid),
        .wr_address(result_address),
        .wr_data(result_data)
    );

    register_bank #(
        .CHANNEL_ADDR_WIDTH(CHANNEL_ADDR_WIDTH)
    ) bank_b (
        .clock(clock),
        .rd_address(operand_b_address),
        .read_data(b_data),
        .wr_valid(result_valid),
        .wr_address(result_address),
        .wr_data(result_data)
    );

    alu_writeback #(
        .CHANNEL_ADDR_WIDTH(CHANNEL_ADDR_WIDTH)
    ) alu (
        .clock(clock),
        .rst(rst),
        .issue(issue.slave),
        .a_data(a_data),
        .b_data(b_data),
        .wr_valid(result_valid),
        .wr_address(result_address),
        .wr_data(result_data)
    );

endmodule

`default_nettype wire

/* design/alu_writeback.sv */
// Integer ALU with issue alignment stage and registered writeback
`timescale 1ns/100ps
`default_nettype none

module alu_writeback #(
    parameter int CHANNEL_ADDR_WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          rst,
    issue_if.slave                        issue,
    input  fcore_pkg::data_t              a_data,
    input  fcore_pkg::data_t              b_data,
    output logic                          wr_valid,
    output logic [CHANNEL_ADDR_WIDTH+3:0] wr_address,
    output fcore_pkg::data_t              wr_data
);
    import fcore_pkg::*;

    localparam int ADDR_WIDTH = CHANNEL_ADDR_WIDTH + 4;

    logic                  stage_valid;
    alu_op_t               stage_op;
    data_t                 stage_imm;
    logic [ADDR_WIDTH-1:0] stage_dest;
    data_t                 result;

    // The banks need one cycle to return operands, so the issue waits here
    always_ff @(posedge clock) begin
        if (rst) begin
            stage_valid <= 1'b0;
            wr_valid    <= 1'b0;
        end else begin
            stage_valid <= issue.valid;
            wr_valid    <= stage_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            stage_op   <= issue.op;
            stage_imm  <= issue.imm;
            stage_dest <= issue.dest;
        end
    end

    always_comb begin
        case (stage_op)
            alu_add:  result = a_data + b_data;
            alu_sub:  result = a_data - b_data;
            alu_and:  result = a_data & b_data;
            alu_or:   result = a_data | b_data;
            alu_not:  result = ~a_data;
            alu_pass: result = stage_imm;
            alu_eq: begin
                result = (a_data == b_data) ? 16'd1 : 16'd0;
            end
            alu_gt: begin
                // Signed compare so that negative values order below positive ones
                result = ($signed(a_data) > $signed(b_data)) ? 16'd1 : 16'd0;
            end
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (stage_valid) begin
            wr_address <= stage_dest;
            wr_data    <= result;
        end
    end

endmodule

`default_nettype wire

/* design/register_bank.sv */
// One copy of the channel register file with a registered read and a write-first bypass
`timescale 1ns/100ps
`default_nettype none

module register_bank #(
    parameter int CHANNEL_ADDR_WIDTH = 2
) (
    input  logic                          clock,
    input  logic [CHANNEL_ADDR_WIDTH+3:0] rd_address,
    output fcore_pkg::data_t              read_data,
    input  logic                          wr_valid,
    input  logic [CHANNEL_ADDR_WIDTH+3:0] wr_address,
    input  fcore_pkg::data_t              wr_data
);
    import fcore_pkg::*;

    // 16 registers for every channel
    localparam int DEPTH = 2 ** (CHANNEL_ADDR_WIDTH + 4);

    data_t registers [DEPTH];

    always_ff @(posedge clock) begin
        if (wr_valid) begin
            registers[wr_address] <= wr_data;
        end
    end

    // A read that meets a write to the same register returns the value being written
    always_ff @(posedge clock) begin
        if (wr_valid && (wr_address == rd_address)) begin
            read_data <= wr_data;
        end else begin
            read_data <= registers[rd_address];
        end
    end

endmodule

`default_nettype wire

/* design/instruction_decoder.sv */
// Instruction decoder with channel relative register addressing and operation issue
`timescale 1ns/100ps
`default_nettype none

module instruction_decoder #(
    parameter int CHANNEL_ADDR_WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          enable,
    input  fcore_pkg::instr_t             instruction,
    input  logic [CHANNEL_ADDR_WIDTH-1:0] channel_address,
    output logic [CHANNEL_ADDR_WIDTH+3:0] operand_a_address,
    output logic [CHANNEL_ADDR_WIDTH+3:0] operand_b_address,
    output logic                          core_stop,
    issue_if.master                       issue
);
    import fcore_pkg::*;

    localparam int ADDR_WIDTH = CHANNEL_ADDR_WIDTH + 4;

    opcode_t               opcode;
    local_reg_t            field_a;
    local_reg_t            field_b;
    local_reg_t            field_dest;
    data_t                 immediate;
    logic [ADDR_WIDTH-1:0] full_a;
    logic [ADDR_WIDTH-1:0] full_b;
    logic [ADDR_WIDTH-1:0] full_dest;
    logic                  issue_op;
    alu_op_t               alu_op;

    assign opcode     = opcode_t'(instruction[3:0]);
    assign field_a    = instruction[7:4];
    assign field_b    = instruction[11:8];
    assign field_dest = instruction[15:12];

    // LDR reuses the B and destination fields as an 8-bit immediate
    assign immediate = {8'h00, instruction[15:8]};

    // Each channel owns 16 registers, so the channel number is the upper address part
    assign full_a    = {channel_address, field_a};
    assign full_b    = {channel_address, field_b};
    assign full_dest = {channel_address, field_dest};

    always_comb begin
        issue_op = 1'b1;
        alu_op   = alu_add;
        case (opcode)
            op_add: alu_op = alu_add;
            op_sub: alu_op = alu_sub;
            op_and: alu_op = alu_and;
            op_or:  alu_op = alu_or;
            op_not: alu_op = alu_not;
            op_ldr: alu_op = alu_pass;
            op_beq: alu_op = alu_eq;
            op_bgt: alu_op = alu_gt;
            // NOP, STOP and the unused codes leave the ALU idle
            default: issue_op = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            issue.valid <= 1'b0;
            core_stop   <= 1'b0;
        end else begin
            issue.valid <= enable && issue_op;
            core_stop   <= enable && (opcode == op_stop);
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            operand_a_address <= full_a;
            operand_b_address <= full_b;
            issue.op          <= alu_op;
            issue.imm         <= immediate;
            // LDR writes to the register named in the operand A field
            if (opcode == op_ldr) begin
                issue.dest <= full_a;
            end else begin
                issue.dest <= full_dest;
            end
        end else begin
            operand_a_address <= '0;
            operand_b_address <= '0;
        end
    end

endmodule

`default_nettype wire

/* design/issue_if.sv */
// Issue interface from the instruction decoder to the ALU
`timescale 1ns/100ps
`default_nettype none

interface issue_if #(
    parameter int CHANNEL_ADDR_WIDTH = 2
);
    import fcore_pkg::*;

    logic                          valid;
    alu_op_t                       op;
    data_t                         imm;
    logic [CHANNEL_ADDR_WIDTH+3:0] dest;

    modport master (
        output valid,
        output op,
        output imm,
        output dest
    );

    modport slave (
        input valid,
        input op,
        input imm,
        input dest
    );

endinterface

`default_nettype wire

/* design/fcore_pkg.sv */
// Instruction, data and register types with the opcode and ALU operation encodings
`default_nettype none

package fcore_pkg;

    // Opcode in 3:0, operand A in 7:4, operand B in 11:8, destination in 15:12
    typedef logic [15:0] instr_t;

    // Register contents, two's complement where a compare needs a sign
    typedef logic [15:0] data_t;

    // Register number inside one channel
    typedef logic [3:0] local_reg_t;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_not  = 4'd5,
        op_ldr  = 4'd6,
        op_beq  = 4'd7,
        op_bgt  = 4'd8,
        op_stop = 4'd12
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_not  = 3'd4,
        alu_pass = 3'd5,
        alu_eq   = 3'd6,
        alu_gt   = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire
